//--- design/frog_settings.svh
/*
 * Frog lane settings
 * Screen bounds, sprite sizes, collision tolerances, pad row layout and hop timing
 */
`ifndef FROG_SETTINGS_SVH
`define FROG_SETTINGS_SVH

// ------------------------------
// Screen geometry
// ------------------------------
`define SCREEN_X_MAX    640     // Right edge where pads wrap
`define SCREEN_Y_START  80      // Frog start row offset from lane
`define FROG_START_X    300     // Frog x after reset

// ------------------------------
// Sprites and collision
// ------------------------------
`define PAD_SIZE        40      // Pad width and height
`define FROG_SIDE       40      // Frog sprite is square
`define X_TOLERANCE     5       // Corner inset on x
`define Y_TOLERANCE     1       // Corner inset on y

// ------------------------------
// Motion
// ------------------------------
`define PAD_STEP        40      // Pixels per pad move
`define LANE_PADS       3       // Pads in the row
`define PAD_SPACING     200     // Start x gap between pads
`define HOP_STEP        40      // Pixels per hop
`define HOP_GAP         2       // Ready low cycles after a hop

`endif

//--- design/frog_pkg.sv
/*
 * Frog lane package
 * Screen coordinate, hop command word with its two payload views,
 * position records and the lane status word
 */
`include "frog_settings.svh"

package frog_pkg;

    typedef logic [10:0] coord_t;          // Wraps mod 2048

    typedef enum logic [1:0] {
        hop_up,
        hop_down,
        hop_left,
        hop_right
    } hop_dir_t;

    typedef enum logic {
        pad_move,                          // Single step cycle
        pad_wait                           // Idle until count hits speed
    } pad_state_t;

    // ------------------------------
    // Hop command
    // ------------------------------
    typedef struct packed {
        hop_dir_t   dir;
        logic [8:0] spare;                 // Not decoded
    } hop_move_t;

    typedef union packed {
        hop_move_t  move;                  // Relative hop
        coord_t     place_x;               // Absolute drop on the start row
    } hop_payload_u;

    typedef struct packed {
        logic         place;               // Selects payload view
        hop_payload_u payload;
    } hop_cmd_t;

    // ------------------------------
    // Positions and status
    // ------------------------------
    typedef struct packed {
        coord_t x;
        coord_t y;
    } frog_pos_t;

    typedef struct packed {
        coord_t x;
        coord_t y;
    } pad_pos_t;

    typedef struct packed {
        logic       direction;             // 0 is left
        logic [5:0] speed;                 // Extra wait cycles per move
    } lane_cfg_t;

    typedef struct packed {
        logic [`LANE_PADS-1:0] hit_mask;   // One bit per pad
        logic                  in_lane;    // Frog band meets lane band
        logic                  on_pad;     // Any pad hit
    } lane_status_t;

endpackage

//--- design/lilypad.sv
/*
 * Lily pad
 * Steps one pad along the lane through a move/wait cycle and wraps it
 * around the screen edges
 */
`timescale 1ns/1ns
`include "frog_settings.svh"

module lilypad (
    input  logic               Reset,       // Frame clock
    input  logic               frame_clk,   // Async reset, active high
    input  frog_pkg::coord_t   start_x,     // Position after reset
    input  frog_pkg::coord_t   lane_y,
    input  logic               direction,   // 0 moves left
    input  logic [5:0]         speed,
    output frog_pkg::pad_pos_t pad,
    output logic [5:0]         wait_count
);
    import frog_pkg::*;

    pad_state_t state;
    pad_state_t next_state;
    coord_t     pad_x;
    coord_t     next_x;
    logic [5:0] count;

    // ------------------------------
    // Step and wrap
    // ------------------------------
    always_comb
    begin
        if (direction == 1'b0)
        begin
            if (coord_t'(pad_x + `PAD_SIZE) == '0)      // Fully off the left edge
                next_x = coord_t'(`SCREEN_X_MAX);       // Reenter from the right
            else
                next_x = coord_t'(pad_x - `PAD_STEP);
        end
        else
        begin
            if (pad_x == coord_t'(`SCREEN_X_MAX))       // Fully off the right edge
                next_x = coord_t'(2048 - `PAD_SIZE);    // Reenter from the left
            else
                next_x = coord_t'(pad_x + `PAD_STEP);
        end
    end

    // Move once, then wait speed+1 cycles
    always_comb
    begin
        next_state = state;
        case (state)
            pad_move: next_state = pad_wait;
            pad_wait: next_state = (count == speed) ? pad_move : pad_wait;
            default:  next_state = pad_move;
        endcase
    end

    always_ff @(posedge Reset or posedge frame_clk)
    begin
        if (frame_clk)
        begin
            state <= pad_move;
            pad_x <= start_x;
            count <= '0;
        end
        else
        begin
            state <= next_state;
            if (state == pad_move)
            begin
                pad_x <= next_x;                        // Step lands as MOVE ends
                count <= '0;
            end
            else
                count <= count + 6'd1;
        end
    end

    assign pad.x      = pad_x;
    assign pad.y      = lane_y;                         // Pads never leave the lane row
    assign wait_count = count;

endmodule

//--- design/pad_overlap.sv
/*
 * Pad overlap
 * Tests the frog's four inset corners against one pad's closed box
 */
`timescale 1ns/1ns
`include "frog_settings.svh"

module pad_overlap (
    input  frog_pkg::frog_pos_t frog,
    input  frog_pkg::pad_pos_t  pad,
    output logic                hit
);
    import frog_pkg::*;

    coord_t left_x;
    coord_t right_x;
    coord_t top_y;
    coord_t bottom_y;
    coord_t pad_right;
    coord_t pad_bottom;
    logic   left_in;
    logic   right_in;
    logic   top_in;
    logic   bottom_in;

    // ------------------------------
    // Inset corners
    // ------------------------------
    assign left_x   = coord_t'(frog.x + `X_TOLERANCE);
    assign right_x  = coord_t'(frog.x - `X_TOLERANCE + `FROG_SIDE);
    assign top_y    = coord_t'(frog.y + `Y_TOLERANCE);
    assign bottom_y = coord_t'(frog.y - `Y_TOLERANCE + `FROG_SIDE);

    assign pad_right  = coord_t'(pad.x + `PAD_SIZE);   // Box edges are inclusive
    assign pad_bottom = coord_t'(pad.y + `PAD_SIZE);

    // Per edge range tests
    assign left_in   = (left_x >= pad.x) && (left_x <= pad_right);
    assign right_in  = (right_x >= pad.x) && (right_x <= pad_right);
    assign top_in    = (top_y >= pad.y) && (top_y <= pad_bottom);
    assign bottom_in = (bottom_y >= pad.y) && (bottom_y <= pad_bottom);

    // Some corner lands inside when an x edge and a y edge both do
    assign hit = (left_in || right_in) && (top_in || bottom_in);

endmodule

//--- design/frog_position.sv
/*
 * Frog position
 * Takes hop commands over a valid/ready handshake, holds the frog
 * coordinates and backs off the source for a few cycles after each hop
 */
`timescale 1ns/1ns
`include "frog_settings.svh"

module frog_position (
    input  logic                Reset,       // Frame clock
    input  logic                frame_clk,   // Async reset, active high
    input  frog_pkg::coord_t    lane_y,
    input  frog_pkg::hop_cmd_t  hop_cmd,
    input  logic                hop_valid,
    output logic                hop_ready,
    output frog_pkg::frog_pos_t frog
);
    import frog_pkg::*;

    localparam int GAP_W = $clog2(`HOP_GAP + 1);

    logic [GAP_W-1:0] gap_cnt;                  // Cooldown after a hop
    logic             take;
    frog_pos_t        next_frog;

    assign take      = hop_valid && hop_ready;
    assign hop_ready = (gap_cnt == '0);

    // ------------------------------
    // Command decode
    // ------------------------------
    always_comb
    begin
        next_frog = frog;
        if (hop_cmd.place)
        begin
            next_frog.x = hop_cmd.payload.place_x;   // Drop onto start row
            next_frog.y = lane_y;
        end
        else
        begin
            case (hop_cmd.payload.move.dir)
                hop_up:    next_frog.y = coord_t'(frog.y - `HOP_STEP);
                hop_down:  next_frog.y = coord_t'(frog.y + `HOP_STEP);
                hop_left:  next_frog.x = coord_t'(frog.x - `HOP_STEP);
                default:   next_frog.x = coord_t'(frog.x + `HOP_STEP);
            endcase
        end
    end

    always_ff @(posedge Reset or posedge frame_clk)
    begin
        if (frame_clk)
        begin
            frog.x  <= coord_t'(`FROG_START_X);
            frog.y  <= coord_t'(lane_y + `SCREEN_Y_START);
            gap_cnt <= '0;
        end
        else if (take)
        begin
            frog    <= next_frog;
            gap_cnt <= GAP_W'(`HOP_GAP);         // Ready drops next cycle
        end
        else if (gap_cnt != '0)
            gap_cnt <= gap_cnt - 1'b1;
    end

endmodule

//--- design/river_lane.sv
/*
 * River lane
 * Builds the pad row, runs one overlap test per pad and registers
 * the lane status each frame clock
 */
`timescale 1ns/1ns
`include "frog_settings.svh"

module river_lane (
    input  logic                                  Reset,       // Frame clock
    input  logic                                  frame_clk,   // Async reset
    input  frog_pkg::coord_t                      lane_y,
    input  logic                                  direction,
    input  logic [5:0]                            speed,
    input  frog_pkg::frog_pos_t                   frog,
    output frog_pkg::pad_pos_t [`LANE_PADS-1:0]   pads,
    output frog_pkg::lane_status_t                status
);
    import frog_pkg::*;

    logic [`LANE_PADS-1:0] hit_c;
    logic                  band_c;
    coord_t                frog_bottom;
    coord_t                lane_bottom;

    // ------------------------------
    // Pad row
    // ------------------------------
    for (genvar n = 0; n < `LANE_PADS; n++)
    begin : g_pad
        localparam coord_t START_X = coord_t'(n * `PAD_SPACING);   // Even spread

        lilypad u_pad (
            .Reset      (Reset),
            .frame_clk  (frame_clk),
            .start_x    (START_X),
            .lane_y     (lane_y),
            .direction  (direction),
            .speed      (speed),
            .pad        (pads[n]),
            .wait_count ()
        );

        pad_overlap u_hit (
            .frog (frog),
            .pad  (pads[n]),
            .hit  (hit_c[n])
        );
    end

    // Y band overlap with the lane row
    assign frog_bottom = coord_t'(frog.y + `FROG_SIDE);
    assign lane_bottom = coord_t'(lane_y + `PAD_SIZE);
    assign band_c      = (frog.y <= lane_bottom) && (lane_y <= frog_bottom);

    always_ff @(posedge Reset or posedge frame_clk)
    begin
        if (frame_clk)
            status <= '0;
        else
        begin
            status.hit_mask <= hit_c;
            status.in_lane  <= band_c;
            status.on_pad   <= |hit_c;              // Water when clear
        end
    end

endmodule

//--- design/river_top.sv
/*
 * River top
 * Joins the hop-driven frog to one lane of drifting pads
 */
`timescale 1ns/1ns
`include "frog_settings.svh"

module river_top (
    input  logic                                Reset,        // Frame clock
    input  logic                                frame_clk,    // Async reset
    input  frog_pkg::hop_cmd_t                  hop_cmd,
    input  logic                                hop_valid,
    input  frog_pkg::coord_t                    lane_y,
    input  frog_pkg::lane_cfg_t                 lane_config,
    output logic                                hop_ready,
    output frog_pkg::frog_pos_t                 frog,
    output frog_pkg::pad_pos_t [`LANE_PADS-1:0] pads,
    output frog_pkg::lane_status_t              status
);

    // ------------------------------
    // Frog
    // ------------------------------
    frog_position u_frog (
        .Reset     (Reset),
        .frame_clk (frame_clk),
        .lane_y    (lane_y),
        .hop_cmd   (hop_cmd),
        .hop_valid (hop_valid),
        .hop_ready (hop_ready),
        .frog      (frog)                    // Also feeds the lane
    );

    // ------------------------------
    // Lane
    // ------------------------------
    river_lane u_lane (
        .Reset     (Reset),
        .frame_clk (frame_clk),
        .lane_y    (lane_y),
        .direction (lane_config.direction),
        .speed     (lane_config.speed),
        .frog      (frog),
        .pads      (pads),
        .status    (status)
    );

endmodule

//--- test/river_tb.sv
/*
 * River lane testbench
 * Applies a table of hop commands in each pad direction, tracks the pads
 * with a cycle-count model and checks frog, handshake, pads and status
 */
`timescale 1ns/1ns
`include "frog_settings.svh"

module river_tb;
    import frog_pkg::*;

    localparam int NUM_ROWS        = 13;
    localparam int LANE_Y          = 300;
    localparam int SPEED           = 3;
    localparam int DRIFT_CYCLES    = 120;                   // Covers wraps of every pad
    localparam int HANDSHAKE_LIMIT = 4 * `HOP_GAP + 4;
    localparam int WATCHDOG_CYCLES = 2 * NUM_ROWS * (`HOP_GAP + 6) + 400;

    typedef struct {
        bit place;
        int arg;                                            // Direction or place x
        int exp_x;
        int exp_y;
        bit exp_lane;
    } hop_row_t;

    logic                       Reset;
    logic                       frame_clk;
    hop_cmd_t                   hop_cmd;
    logic                       hop_valid;
    coord_t                     lane_y;
    lane_cfg_t                  lane_config;
    logic                       hop_ready;
    frog_pos_t                  frog;
    pad_pos_t [`LANE_PADS-1:0]  pads;
    lane_status_t               status;

    hop_row_t              hop_table [NUM_ROWS];
    int                    edge_count;                      // Rising edges since reset release
    int                    errors;
    int                    tests;
    int                    failed;
    int                    exp_x;
    int                    exp_y;
    int                    ready_hold;                      // Cycles hop_ready must stay low
    bit                    exp_lane_now;
    bit                    checking;
    bit                    hung;
    bit                    cur_dir;
    logic [`LANE_PADS-1:0] exp_mask;                        // Status due at the next edge
    bit                    exp_in_lane;
    bit                    exp_on_pad;
    int unsigned           seed_draw;

    river_top dut (
        .Reset       (Reset),
        .frame_clk   (frame_clk),
        .hop_cmd     (hop_cmd),
        .hop_valid   (hop_valid),
        .lane_y      (lane_y),
        .lane_config (lane_config),
        .hop_ready   (hop_ready),
        .frog        (frog),
        .pads        (pads),
        .status      (status)
    );

    initial
    begin
        Reset = 1'b0;
        forever #10 Reset = ~Reset;
    end

    always @(posedge Reset)
    begin
        if (frame_clk)
            edge_count <= 0;
        else
            edge_count <= edge_count + 1;
    end

    // ------------------------------
    // Reference models
    // ------------------------------
    function automatic int model_pad_x(input int n, input bit dir, input int k);
        int x;
        int steps;
        x     = n * `PAD_SPACING;
        steps = (k == 0) ? 0 : (k - 1) / (SPEED + 2) + 1;  // One step per move/wait round
        repeat (steps)
        begin
            if (!dir)
                x = (((x + `PAD_SIZE) % 2048) == 0) ? `SCREEN_X_MAX : (x - `PAD_STEP + 2048) % 2048;
            else
                x = (x == `SCREEN_X_MAX) ? 2048 - `PAD_SIZE : (x + `PAD_STEP) % 2048;
        end
        return x;
    endfunction

    function automatic bit corner_hit(input int fx, input int fy, input int px, input int py);
        int cx;
        int cy;
        bit hit;
        hit = 1'b0;
        for (int c = 0; c < 4; c++)
        begin
            cx  = c[0] ? (fx - `X_TOLERANCE + `FROG_SIDE) & 2047 : (fx + `X_TOLERANCE) & 2047;
            cy  = c[1] ? (fy - `Y_TOLERANCE + `FROG_SIDE) & 2047 : (fy + `Y_TOLERANCE) & 2047;
            hit = hit | ((cx >= px) && (cx <= ((px + `PAD_SIZE) & 2047))
                      && (cy >= py) && (cy <= ((py + `PAD_SIZE) & 2047)));
        end
        return hit;
    endfunction

    function automatic hop_cmd_t make_cmd(input bit place, input int arg);
        hop_cmd_t cmd;
        cmd       = '0;
        cmd.place = place;
        if (place)
            cmd.payload.place_x = coord_t'(arg);
        else
            cmd.payload.move.dir = hop_dir_t'(arg);
        return cmd;
    endfunction

    task automatic check_val(input string what, input int got, input int exp);
        assert (got == exp)
        else
        begin
            $display("FAIL %s exp %0h got %0h", what, exp, got);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int err_before);
        tests++;
        if (errors != err_before)
        begin
            failed++;
            $display("test %s: failed with %0d errors", name, errors - err_before);
        end
        else
            $display("test %s: ok", name);
    endtask

    task automatic load_table();
        hop_table[0]  = '{1'b0, hop_up,    300, 340, 1'b1};  // Y tolerance keeps corners off
        hop_table[1]  = '{1'b0, hop_up,    300, 300, 1'b1};
        hop_table[2]  = '{1'b1, 35,        35,  300, 1'b1};  // Left corner on a box edge
        hop_table[3]  = '{1'b0, hop_right, 75,  300, 1'b1};
        hop_table[4]  = '{1'b0, hop_left,  35,  300, 1'b1};
        hop_table[5]  = '{1'b1, 196,       196, 300, 1'b1};
        hop_table[6]  = '{1'b0, hop_left,  156, 300, 1'b1};
        hop_table[7]  = '{1'b0, hop_down,  156, 340, 1'b1};
        hop_table[8]  = '{1'b0, hop_down,  156, 380, 1'b0};
        hop_table[9]  = '{1'b0, hop_down,  156, 420, 1'b0};
        hop_table[10] = '{1'b1, 600,       600, 300, 1'b1};
        hop_table[11] = '{1'b0, hop_up,    600, 260, 1'b1};  // Bands touch at one row
        hop_table[12] = '{1'b0, hop_up,    600, 220, 1'b0};
    endtask

    // ------------------------------
    // Cycle monitor
    // ------------------------------
    always @(negedge Reset)
    begin
        if (checking)
        begin
            check_val("frog.x", frog.x, exp_x);
            check_val("frog.y", frog.y, exp_y);
            check_val("hop_ready", hop_ready, ready_hold == 0);
            if (ready_hold > 0)
                ready_hold--;
            check_val("status.hit_mask", status.hit_mask, exp_mask);
            check_val("status.in_lane", status.in_lane, exp_in_lane);
            check_val("status.on_pad", status.on_pad, exp_on_pad);
            for (int n = 0; n < `LANE_PADS; n++)
            begin
                check_val($sformatf("pads[%0d].x", n), pads[n].x, model_pad_x(n, cur_dir, edge_count));
                check_val($sformatf("pads[%0d].y", n), pads[n].y, LANE_Y);
                exp_mask[n] = corner_hit(exp_x, exp_y, model_pad_x(n, cur_dir, edge_count), LANE_Y);
            end
            exp_in_lane = exp_lane_now;                     // Registered on the next edge
            exp_on_pad  = |exp_mask;
        end
    end

    task automatic apply_row(input int idx, input int gap, input bit first);
        int waited;
        int err_before;
        err_before = errors;
        repeat (gap) @(posedge Reset);
        if (gap > 0)
            #2;
        hop_cmd   = make_cmd(hop_table[idx].place, hop_table[idx].arg);
        hop_valid = 1'b1;
        waited    = 0;
        @(negedge Reset);
        while (!hop_ready && waited < HANDSHAKE_LIMIT)
        begin
            waited++;
            @(negedge Reset);
        end
        if (!hop_ready)
        begin
            $display("hop %0d was never accepted, hop_ready stayed low", idx);
            errors++;
            hung      = 1'b1;
            checking  = 1'b0;
            hop_valid = 1'b0;
        end
        else
        begin
            check_val("hop_wait_cycles", waited, (first || gap >= `HOP_GAP) ? 0 : `HOP_GAP - gap);
            @(posedge Reset);                               // Transfer edge
            #2;
            hop_valid    = 1'b0;
            exp_x        = hop_table[idx].exp_x;
            exp_y        = hop_table[idx].exp_y;
            exp_lane_now = hop_table[idx].exp_lane;
            ready_hold   = `HOP_GAP;
        end
        report_test($sformatf("dir %0d hop %0d gap %0d", cur_dir, idx, gap), err_before);
    endtask

    // ------------------------------
    // Main sequence
    // ------------------------------
    initial
    begin
        int err_before;
        frame_clk         = 1'b1;
        hop_valid         = 1'b0;
        hop_cmd           = '0;
        lane_y            = coord_t'(LANE_Y);
        lane_config       = '0;
        lane_config.speed = 6'(SPEED);
        checking          = 1'b0;
        hung              = 1'b0;
        errors            = 0;
        tests             = 0;
        failed            = 0;
        seed_draw         = $urandom(1);
        load_table();
        for (int ph = 0; ph < 2 && !hung; ph++)
        begin
            frame_clk             = 1'b1;
            checking              = 1'b0;
            cur_dir               = ph[0];
            lane_config.direction = ph[0];                  // Left first, then right
            repeat (10) @(posedge Reset);
            #2;
            frame_clk    = 1'b0;
            exp_x        = `FROG_START_X;
            exp_y        = LANE_Y + `SCREEN_Y_START;
            exp_lane_now = 1'b0;
            ready_hold   = 0;
            exp_mask     = '0;
            exp_in_lane  = 1'b0;
            exp_on_pad   = 1'b0;
            checking     = 1'b1;
            for (int i = 0; i < NUM_ROWS && !hung; i++)
                apply_row(i, $urandom % 4, i == 0);
            if (!hung)
            begin
                err_before = errors;
                while (edge_count < DRIFT_CYCLES)
                    @(posedge Reset);
                #2;
                report_test($sformatf("dir %0d pad drift", cur_dir), err_before);
            end
        end
        checking = 1'b0;
        $display("tests %0d, failed %0d, errors %0d", tests, failed, errors);
        if (errors == 0 && !hung)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

    initial
    begin
        repeat (WATCHDOG_CYCLES) @(posedge Reset);
        $display("watchdog: run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

//--- all.f
+incdir+design
design/frog_pkg.sv
design/lilypad.sv
design/pad_overlap.sv
design/frog_position.sv
design/river_lane.sv
design/river_top.sv
test/river_tb.sv

//--- Bender.yml
package:
  name: river_lane

sources:
  - include_dirs:
      - design
    files:
      - design/frog_pkg.sv
      - design/lilypad.sv
      - design/pad_overlap.sv
      - design/frog_position.sv
      - design/river_lane.sv
      - design/river_top.sv
  - target: test
    include_dirs:
      - design
    files:
      - test/river_tb.sv
